//--- src/dcu_wa_addr_pkg.sv
// PALEN up to 32 and a power-of-two LINE_BYTES from 8 to 64 fit the fixed maximum widths.
package dcu_wa_addr_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int PALEN_MAX      = 32;
    localparam int LINE_BYTES_MAX = 64;
    localparam int WORD_LSB       = 2;                      // byte offset within a word.
    localparam int TAG_W          = PALEN_MAX - WORD_LSB - 1; // room for an 8-byte line.
    localparam int CNT_W          = 7;

    typedef logic [PALEN_MAX-1:0]      paddr_t;
    typedef logic [TAG_W-1:0]          line_tag_t;
    typedef logic [LINE_BYTES_MAX-1:0] line_mask_t;   // one bit per byte.
    typedef logic [3:0]                wmask_t;
    typedef logic [CNT_W-1:0]          line_cnt_t;

    // offset width of a line of the given size.
    function automatic int line_off_w(input int line_bytes);
        return $clog2(line_bytes);
    endfunction

    // tag bits that an address of palen bits really carries.
    function automatic int line_tag_w(input int palen, input int line_bytes);
        return palen - $clog2(line_bytes);
    endfunction

endpackage

//--- src/dcu_wa_ops_pkg.sv
// commit function bits follow the LSU commit encoding; a load or store needs the memory bit too.
package dcu_wa_ops_pkg;
    import dcu_wa_addr_pkg::*;

    // ==================================================
    // commit function bit positions
    // ==================================================
    localparam int FUNC_MEM   = 0;
    localparam int FUNC_LOAD  = 1;
    localparam int FUNC_STORE = 2;

    // one decoded commit that is valid in its commit cycle only.
    typedef struct packed {
        logic       live;       // valid, not killed, some byte written.
        logic       is_store;
        logic       is_load;
        line_tag_t  tag;
        line_mask_t bytes;      // word mask placed within the line.
    } cmt_op_t;

    // tracker view of the held line against the current commit.
    typedef struct packed {
        logic same_line;
        logic line_full;
        logic count_reached;
        logic cfg_changed;
        logic break_stream;
    } line_status_t;

    // write-around mode states.
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        DETECT = 2'd1,
        WA     = 2'd2
    } wa_state_e;

endpackage

//--- src/dcu_wa_cmt_decode.sv
// purely combinational; the line offset must hold at least one word above the byte offset.
`timescale 1ns/1ps

module dcu_wa_cmt_decode
    import dcu_wa_addr_pkg::*;
    import dcu_wa_ops_pkg::*;
#(
    parameter int PALEN      = 32,
    parameter int LINE_BYTES = 64
) (
    input  logic       cmt_valid,
    input  logic       cmt_kill,
    input  paddr_t     cmt_addr,
    input  wmask_t     cmt_wmask,
    input  logic [2:0] cmt_func,
    output cmt_op_t    op
);

    localparam int OFF_W = line_off_w(LINE_BYTES);
    localparam int TW    = line_tag_w(PALEN, LINE_BYTES);

    logic [TW-1:0]    addr_tag;
    logic [OFF_W-1:0] byte_pos;     // first byte of the word in the line.
    logic             qualified;

    assign addr_tag  = cmt_addr[PALEN-1:OFF_W];
    assign byte_pos  = {cmt_addr[OFF_W-1:WORD_LSB], {WORD_LSB{1'b0}}};
    assign qualified = cmt_valid & ~cmt_kill & (|cmt_wmask);

    // ==================================================
    // classify and place
    // ==================================================
    always_comb begin
        op          = '0;
        op.is_store = cmt_func[FUNC_MEM] & cmt_func[FUNC_STORE];
        op.is_load  = cmt_func[FUNC_MEM] & cmt_func[FUNC_LOAD];
        op.live     = qualified;
        op.tag      = line_tag_t'(addr_tag);
        op.bytes    = line_mask_t'(cmt_wmask) << byte_pos;
    end

endmodule

//--- src/dcu_wa_line_track.sv
// holds one line at a time; the held tag is meaningful only after arm.
`timescale 1ns/1ps

module dcu_wa_line_track
    import dcu_wa_addr_pkg::*;
    import dcu_wa_ops_pkg::*;
#(
    parameter int PALEN      = 32,
    parameter int LINE_BYTES = 64
) (
    input  logic         dcu_clk,
    input  logic         dcu_reset_n,
    input  cmt_op_t      op,
    input  logic [1:0]   waround_cfg,
    input  logic         arm,
    input  logic         active,
    output line_status_t status
);

    localparam int TW = line_tag_w(PALEN, LINE_BYTES);

    logic [TW-1:0] tag_q;
    line_mask_t    mask_q;
    line_cnt_t     cnt_q;
    logic [1:0]    cfg_q;          // field seen at arm.
    line_cnt_t     threshold;
    logic          st_live;
    logic          ld_live;
    logic          cnt_inc;

    assign st_live = op.live & op.is_store;
    assign ld_live = op.live & op.is_load;

    always_comb begin
        case (cfg_q)
            2'd1:    threshold = line_cnt_t'(3);
            2'd2:    threshold = line_cnt_t'(63);
            default: threshold = line_cnt_t'(127);
        endcase
    end

    // ==================================================
    // line status
    // ==================================================
    always_comb begin
        status               = '0;
        status.same_line     = (op.tag[TW-1:0] == tag_q);
        status.line_full     = &mask_q[LINE_BYTES-1:0];
        status.count_reached = (cnt_q == threshold);
        status.cfg_changed   = (cfg_q != waround_cfg);
        status.break_stream  = (st_live & ~status.same_line & ~status.line_full)
                             | (ld_live & status.same_line)
                             | status.cfg_changed;
    end

    // a full line followed by a store elsewhere extends the run.
    assign cnt_inc = active & st_live & ~status.same_line & status.line_full
                   & ~status.count_reached;

    always_ff @(posedge dcu_clk) begin
        if (arm || (active && st_live && !status.same_line)) begin
            tag_q <= op.tag[TW-1:0];
        end
    end

    always_ff @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            mask_q <= '0;
            cnt_q  <= '0;
            cfg_q  <= 2'd0;
        end else begin
            if (arm) begin
                mask_q <= op.bytes;
            end else if (active && st_live) begin
                mask_q <= (status.same_line ? mask_q : '0) | op.bytes; // new line starts fresh.
            end
            if (arm || (active && status.break_stream)) begin
                cnt_q <= '0;
            end else if (cnt_inc) begin
                cnt_q <= cnt_q + line_cnt_t'(1);
            end
            if (arm) begin
                cfg_q <= waround_cfg;
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_cnt_bound: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        cnt_q <= threshold);
    a_arm_excl: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        !(arm && active));

endmodule

//--- src/dcu_wa_mode_fsm.sv
// wna_mode is combinational on the commit cycle; the field is sampled live every cycle.
`timescale 1ns/1ps

module dcu_wa_mode_fsm
    import dcu_wa_ops_pkg::*;
(
    input  logic         dcu_clk,
    input  logic         dcu_reset_n,
    input  logic [1:0]   waround_cfg,
    input  cmt_op_t      op,
    input  line_status_t status,
    output logic         arm,
    output logic         active,
    output logic         wna_mode
);

    wa_state_e state_q;
    wa_state_e state_d;

    always_ff @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (waround_cfg != 2'd0) begin
                    state_d = DETECT;
                end
            end
            DETECT: begin
                if (status.cfg_changed) begin
                    state_d = IDLE;
                end else if (status.line_full && status.count_reached) begin
                    state_d = WA;
                end
            end
            WA: begin
                if (status.cfg_changed) begin
                    state_d = IDLE;
                end else if (status.break_stream) begin
                    state_d = DETECT;  // count again after a broken stream.
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign arm      = (state_q == IDLE) && (waround_cfg != 2'd0);
    assign active   = (state_q != IDLE);
    assign wna_mode = ((state_q == WA) && (status.same_line || status.line_full))
                    || ((state_q == DETECT) && status.line_full && status.count_reached);

    // ==================================================
    // checks
    // ==================================================
    a_idle_quiet: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        (state_q == IDLE) |-> !wna_mode);
    a_wa_drop: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        (state_q == DETECT) && ($past(state_q) == WA) |-> $past(op.live));

endmodule

//--- src/dcu_wa_top.sv
// address and line sizes are set here only; cmt_addr bits at PALEN and above are ignored.
`timescale 1ns/1ps

module dcu_wa_top
    import dcu_wa_addr_pkg::*;
    import dcu_wa_ops_pkg::*;
#(
    parameter int PALEN      = 32,
    parameter int LINE_BYTES = 64
) (
    input  logic       dcu_clk,
    input  logic       dcu_reset_n,
    input  logic [1:0] waround_cfg,
    input  logic       cmt_valid,
    input  logic       cmt_kill,
    input  paddr_t     cmt_addr,
    input  wmask_t     cmt_wmask,
    input  logic [2:0] cmt_func,
    output logic       wna_mode
);

    cmt_op_t      op;
    line_status_t status;
    logic         arm;
    logic         active;

    dcu_wa_cmt_decode #(
        .PALEN      (PALEN),
        .LINE_BYTES (LINE_BYTES)
    ) u_cmt_decode (
        .cmt_valid (cmt_valid),
        .cmt_kill  (cmt_kill),
        .cmt_addr  (cmt_addr),
        .cmt_wmask (cmt_wmask),
        .cmt_func  (cmt_func),
        .op        (op)
    );

    dcu_wa_line_track #(
        .PALEN      (PALEN),
        .LINE_BYTES (LINE_BYTES)
    ) u_line_track (
        .dcu_clk     (dcu_clk),
        .dcu_reset_n (dcu_reset_n),
        .op          (op),
        .waround_cfg (waround_cfg),
        .arm         (arm),
        .active      (active),
        .status      (status)
    );

    dcu_wa_mode_fsm u_mode_fsm (
        .dcu_clk     (dcu_clk),
        .dcu_reset_n (dcu_reset_n),
        .waround_cfg (waround_cfg),
        .op          (op),
        .status      (status),
        .arm         (arm),
        .active      (active),
        .wna_mode    (wna_mode)
    );

endmodule

//--- sim/dcu_wa_tb.sv
// model assumes 64-byte lines and a 32-bit address; streams are full-word stores in address order.
`timescale 1ns/1ps

module dcu_wa_tb;

    localparam int RAND_CYCLES = 60;
    localparam int TEST_CYCLES = 8 + 16 * 119 + 6 * RAND_CYCLES + 40;
    localparam int MAX_CYCLES  = TEST_CYCLES + 200;
    localparam logic [2:0] F_STORE = 3'b101;
    localparam logic [2:0] F_LOAD  = 3'b011;
    localparam int S_IDLE   = 0;
    localparam int S_DETECT = 1;
    localparam int S_WA     = 2;

    logic        dcu_clk;
    logic        dcu_reset_n;
    logic [1:0]  waround_cfg;
    logic        cmt_valid;
    logic        cmt_kill;
    logic [31:0] cmt_addr;
    logic [3:0]  cmt_wmask;
    logic [2:0]  cmt_func;
    logic        wna_mode;

    string       test_name;
    int          error_count = 0;
    int          cycle_count = 0;
    logic [31:0] rbase;
    logic        want_low, want_high;   // set by the test and copied on each commit.
    logic        hold_low, hold_high;

    // ==================================================
    // reference model
    // ==================================================
    int          m_state;
    logic [25:0] m_tag;
    logic [63:0] m_mask;
    logic [6:0]  m_cnt;
    logic [1:0]  m_cfg;
    logic [25:0] c_tag;
    logic [63:0] c_bytes;
    logic [6:0]  c_thr;
    logic        c_live, c_st, c_ld, c_same, c_full, c_reached, c_changed, c_break;
    logic        exp_wna;

    dcu_wa_top #(.PALEN(32), .LINE_BYTES(64)) i_dcu_wa_top (.*);

    always #10 dcu_clk = ~dcu_clk;

    always_comb begin
        c_tag     = cmt_addr[31:6];
        c_bytes   = {60'd0, cmt_wmask} << {cmt_addr[5:2], 2'b00};
        c_live    = cmt_valid && !cmt_kill && (cmt_wmask != 4'd0);
        c_st      = c_live && cmt_func[0] && cmt_func[2];
        c_ld      = c_live && cmt_func[0] && cmt_func[1];
        c_same    = (c_tag == m_tag);
        c_full    = (m_mask == '1);
        c_thr     = (m_cfg == 2'd1) ? 7'd3 : ((m_cfg == 2'd2) ? 7'd63 : 7'd127);
        c_reached = (m_cnt == c_thr);
        c_changed = (m_cfg != waround_cfg);
        c_break   = (c_st && !c_same && !c_full) || (c_ld && c_same) || c_changed;
        exp_wna   = ((m_state == S_WA) && (c_same || c_full))
                  || ((m_state == S_DETECT) && c_full && c_reached);
    end

    always @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            m_state <= S_IDLE;
            m_tag   <= '0;
            m_mask  <= '0;
            m_cnt   <= '0;
            m_cfg   <= 2'd0;
        end else if (m_state == S_IDLE) begin
            if (waround_cfg != 2'd0) begin
                m_state <= S_DETECT;  // arm takes whatever the commit carries.
                m_tag   <= c_tag;
                m_mask  <= c_bytes;
                m_cnt   <= '0;
                m_cfg   <= waround_cfg;
            end
        end else begin
            if (c_changed) begin
                m_state <= S_IDLE;
            end else if ((m_state == S_DETECT) && c_full && c_reached) begin
                m_state <= S_WA;
            end else if ((m_state == S_WA) && c_break) begin
                m_state <= S_DETECT;
            end
            if (c_st) begin
                m_tag  <= c_tag;
                m_mask <= c_same ? (m_mask | c_bytes) : c_bytes;
            end
            if (c_break) begin
                m_cnt <= '0;
            end else if (c_st && !c_same && c_full && !c_reached) begin
                m_cnt <= m_cnt + 7'd1;
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    task automatic flag_mismatch(input logic exp, input logic act);
        error_count++;
        $display("error %s: wna_mode expected %0b actual %0b", test_name, exp, act);
    endtask

    a_model: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        wna_mode == exp_wna) else flag_mismatch($sampled(exp_wna), $sampled(wna_mode));
    a_idle: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        (m_state == S_IDLE) |-> !wna_mode) else flag_mismatch(1'b0, $sampled(wna_mode));
    a_low: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        hold_low |-> !wna_mode) else flag_mismatch(1'b0, $sampled(wna_mode));
    a_high: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        hold_high |-> wna_mode) else flag_mismatch(1'b1, $sampled(wna_mode));
    a_load_drop: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        (m_state == S_WA) && c_ld && c_same |=> !wna_mode)
        else flag_mismatch(1'b0, $sampled(wna_mode));
    a_cfg_drop: assert property (@(posedge dcu_clk) disable iff (!dcu_reset_n)
        (m_state == S_WA) && c_changed |=> !wna_mode)
        else flag_mismatch(1'b0, $sampled(wna_mode));

    always @(posedge dcu_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    task automatic commit(input logic [31:0] addr, input logic [3:0] wmask,
                          input logic [2:0] func, input logic kill);
        @(negedge dcu_clk);
        cmt_valid = 1'b1;
        cmt_kill  = kill;
        cmt_addr  = addr;
        cmt_wmask = wmask;
        cmt_func  = func;
        hold_low  = want_low;
        hold_high = want_high;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge dcu_clk);
            cmt_valid = 1'b0;
            cmt_kill  = 1'b0;
            cmt_addr  = '0;
            cmt_wmask = '0;
            cmt_func  = '0;
            hold_low  = 1'b0;
            hold_high = 1'b0;
        end
    endtask

    task automatic change_cfg(input logic [1:0] code);
        drive_idle(1);
        waround_cfg = code;     // same cycle as the idle commit.
    endtask

    task automatic write_line(input logic [31:0] base, input int words);
        for (int w = 0; w < words; w++) begin
            commit(base + 32'(w * 4), 4'hf, F_STORE, 1'b0);
        end
    endtask

    // lines below n_low keep wna_mode low and later ones hold it high.
    task automatic stream(input logic [31:0] base, input int n_lines, input int n_low);
        for (int i = 0; i < n_lines; i++) begin
            want_low  = (i < n_low);
            want_high = (i >= n_low);
            write_line(base + 32'(i * 64), 16);
        end
        want_low  = 1'b0;
        want_high = 1'b0;
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] base;
        base = $urandom & 32'hffff_ffc0;
        repeat (n) begin
            @(negedge dcu_clk);
            cmt_valid = (($urandom % 8) != 0);
            cmt_kill  = (($urandom % 8) == 0);
            cmt_addr  = base + ($urandom % 3) * 64 + ($urandom % 16) * 4;
            cmt_wmask = 4'($urandom);
            cmt_func  = 3'($urandom);
            if (($urandom % 40) == 0) begin
                waround_cfg = 2'($urandom);
            end
        end
    endtask

    initial begin
        dcu_clk = 1'b0;
        dcu_reset_n = 1'b0;
        waround_cfg = 2'd0;
        cmt_valid = 1'b0;
        cmt_kill = 1'b0;
        cmt_addr = '0;
        cmt_wmask = '0;
        cmt_func = '0;
        {want_low, want_high, hold_low, hold_high} = '0;
        test_name = "reset";
        void'($urandom(32'h5a7e));
        repeat (8) @(negedge dcu_clk);
        dcu_reset_n = 1'b1;
        drive_idle(2);

        test_name = "cfg_off";
        stream(32'h0001_0000, 6, 6);
        test_name = "stream_code1";
        change_cfg(2'd1);
        drive_idle(2);
        stream(32'h0002_0000, 5, 4);
        test_name = "load_hit";
        commit(32'h0002_0108, 4'hf, F_LOAD, 1'b0);    // held line is base + 0x100.
        commit(32'h0002_010c, 4'hf, F_STORE, 1'b0);
        test_name = "partial_restart";
        want_low = 1'b1;
        write_line(32'h0003_0000, 16);
        write_line(32'h0003_0040, 16);
        write_line(32'h0003_0080, 8);
        stream(32'h0003_0100, 5, 4);
        test_name = "cfg_change";
        change_cfg(2'd2);
        drive_idle(2);
        test_name = "stream_code2";
        stream(32'h0004_0000, 65, 64);

        test_name = "kill_zero_mask";
        change_cfg(2'd1);
        drive_idle(2);
        want_low = 1'b1;
        write_line(32'h0005_0000, 16);
        write_line(32'h0005_0040, 16);
        commit(32'h0005_0400, 4'hf, F_STORE, 1'b1);
        commit(32'h0005_0440, 4'h0, F_STORE, 1'b0);
        write_line(32'h0005_0080, 16);
        write_line(32'h0005_00c0, 16);
        stream(32'h0005_0100, 1, 0);

        test_name = "random_mix";
        for (int r = 0; r < 6; r++) begin
            rbase = $urandom & 32'hffff_ffc0;
            for (int k = 0; k < 5; k++) begin
                write_line(rbase + 32'(k * 64), 16);
            end
            random_traffic(RAND_CYCLES);
        end
        drive_idle(4);

        $display("checks done after %0d cycles with %0d errors", cycle_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
src/dcu_wa_addr_pkg.sv
src/dcu_wa_ops_pkg.sv
src/dcu_wa_cmt_decode.sv
src/dcu_wa_line_track.sv
src/dcu_wa_mode_fsm.sv
src/dcu_wa_top.sv
sim/dcu_wa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the write-around detector testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

TOP=dcu_wa_tb
LOG=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module "$TOP" -o "$TOP"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "no pass message found in $LOG"
    exit 1
fi
exit 0
